/* common/ppu_reg_params.svh */
`ifndef PPU_REG_PARAMS_SVH
`define PPU_REG_PARAMS_SVH

// widths
`define PPU_DATA_W          8
`define PPU_LOOPY_W         15
`define PPU_FINE_X_W        3
`define PPU_VRAM_AW         11
`define PPU_PAL_AW          5

// region bounds on the low 14 bits of v
`define PPU_NT_BASE         14'h2000
`define PPU_PAL_BASE        14'h3F00

// data port steps, selected by ppuctrl bit 2
`define PPU_INC_ACROSS      15'd1
`define PPU_INC_DOWN        15'd32

// coarse scroll limits
`define PPU_COARSE_MAX      5'd31
`define PPU_COARSE_ROWS_END 5'd29

`endif

/* common/ppu_bus_pkg.sv */
`default_nettype none

`include "ppu_reg_params.svh"

package ppu_bus_pkg;

    // one byte on the CPU data bus
    typedef logic [`PPU_DATA_W-1:0] ppu_byte_t;

    // register offsets, 3 and 4 are the OAM registers and are not decoded
    typedef enum logic [2:0] {
        PPUCTRL   = 3'd0,
        PPUMASK   = 3'd1,
        PPUSTATUS = 3'd2,
        PPUSCROLL = 3'd5,
        PPUADDR   = 3'd6,
        PPUDATA   = 3'd7
    } reg_sel_t;

    // shared by PPUSCROLL and PPUADDR
    typedef enum logic {
        FIRST_WRITE,
        SECOND_WRITE
    } wr_toggle_t;

endpackage

`default_nettype wire

/* common/ppu_vram_pkg.sv */
`default_nettype none

`include "ppu_reg_params.svh"

package ppu_vram_pkg;

    // loopy layout: fine Y [14:12], nametable [11:10], coarse Y [9:5], coarse X [4:0]
    typedef logic [`PPU_LOOPY_W-1:0] loopy_addr_t;

    typedef logic [`PPU_FINE_X_W-1:0] fine_x_t;

    // 2 KiB of nametable RAM
    typedef logic [`PPU_VRAM_AW-1:0] vram_addr_t;

    // 32 palette entries
    typedef logic [`PPU_PAL_AW-1:0] pal_addr_t;

    typedef enum logic {
        MIRROR_HORIZONTAL,
        MIRROR_VERTICAL
    } mirror_t;

    typedef enum logic [1:0] {
        REGION_PATTERN,
        REGION_NAMETABLE,
        REGION_PALETTE
    } mem_region_t;

endpackage

`default_nettype wire

/* scroll/loopy_addr_reg.sv */
`default_nettype none

`include "ppu_reg_params.svh"

module loopy_addr_reg (
    input  wire                        clk,
    input  wire                        rst_n,
    input  wire logic                  v_load,
    input  wire logic                  t_load,
    input  wire logic                  fine_x_load,
    input  wire ppu_vram_pkg::loopy_addr_t v_in,
    input  wire ppu_vram_pkg::loopy_addr_t t_in,
    input  wire ppu_vram_pkg::fine_x_t     fine_x_in,
    input  wire logic                  h_scroll,
    input  wire logic                  v_scroll,
    input  wire logic                  h_update,
    input  wire logic                  v_update,
    input  wire logic                  rendering,
    output ppu_vram_pkg::loopy_addr_t  v_addr,
    output ppu_vram_pkg::loopy_addr_t  t_addr,
    output ppu_vram_pkg::fine_x_t      fine_x
);
    import ppu_vram_pkg::*;

    loopy_addr_t v_next;
    logic [4:0]  coarse_x;
    logic [4:0]  coarse_y;
    logic [2:0]  fine_y;

    assign coarse_x = v_addr[4:0];
    assign coarse_y = v_addr[9:5];
    assign fine_y   = v_addr[14:12];

    // cpu load first, then the render-time operations in priority order
    always_comb begin
        v_next = v_addr;
        if (v_load) begin
            v_next = v_in;
        end else if (rendering) begin
            if (h_scroll) begin
                if (coarse_x == `PPU_COARSE_MAX) begin
                    v_next[4:0] = 5'd0;
                    v_next[10]  = ~v_addr[10];
                end else begin
                    v_next[4:0] = coarse_x + 5'd1;
                end
            end else if (v_scroll) begin
                if (fine_y != 3'd7) begin
                    v_next[14:12] = fine_y + 3'd1;
                end else begin
                    v_next[14:12] = 3'd0;
                    // row 29 is the last visible tile row
                    if (coarse_y == `PPU_COARSE_ROWS_END) begin
                        v_next[9:5] = 5'd0;
                        v_next[11]  = ~v_addr[11];
                    end else if (coarse_y == `PPU_COARSE_MAX) begin
                        v_next[9:5] = 5'd0;
                    end else begin
                        v_next[9:5] = coarse_y + 5'd1;
                    end
                end
            end else if (h_update) begin
                v_next[10]  = t_addr[10];
                v_next[4:0] = t_addr[4:0];
            end else if (v_update) begin
                v_next[14:11] = t_addr[14:11];
                v_next[9:5]   = t_addr[9:5];
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            v_addr <= '0;
            t_addr <= '0;
            fine_x <= '0;
        end else begin
            v_addr <= v_next;
            if (t_load) begin
                t_addr <= t_in;
            end
            if (fine_x_load) begin
                fine_x <= fine_x_in;
            end
        end
    end

endmodule

`default_nettype wire

/* source/ppu_mem_map.sv */
`default_nettype none

`include "ppu_reg_params.svh"

module ppu_mem_map (
    input  wire ppu_vram_pkg::loopy_addr_t v_addr,
    input  wire ppu_vram_pkg::mirror_t     mirroring,
    output ppu_vram_pkg::mem_region_t      region,
    output ppu_vram_pkg::vram_addr_t       vram_addr,
    output ppu_vram_pkg::pal_addr_t        pal_addr
);
    import ppu_vram_pkg::*;

    // bit 14 of v is fine Y only, the bus sees 14 bits
    logic [13:0] map_addr;

    assign map_addr = v_addr[13:0];

    always_comb begin
        if (map_addr < `PPU_NT_BASE) begin
            region = REGION_PATTERN;
        end else if (map_addr < `PPU_PAL_BASE) begin
            region = REGION_NAMETABLE;
        end else begin
            region = REGION_PALETTE;
        end
    end

    // two physical tables, picked by bit 10 or bit 11
    always_comb begin
        if (mirroring == MIRROR_VERTICAL) begin
            vram_addr = {map_addr[10], map_addr[9:0]};
        end else begin
            vram_addr = {map_addr[11], map_addr[9:0]};
        end
    end

    // sprite backdrop entries share the background ones
    always_comb begin
        if (map_addr[4] && (map_addr[1:0] == 2'b00)) begin
            pal_addr = {1'b0, map_addr[3:0]};
        end else begin
            pal_addr = map_addr[4:0];
        end
    end

endmodule

`default_nettype wire

/* source/ppu_status_flags.sv */
`default_nettype none

module ppu_status_flags (
    input  wire logic                  clk,
    input  wire logic                  rst_n,
    input  wire logic                  sp_over_set,
    input  wire logic                  sp_over_clr,
    input  wire logic                  sp_zero_set,
    input  wire logic                  sp_zero_clr,
    input  wire logic                  vblank_set,
    input  wire logic                  vblank_clr,
    input  wire logic                  status_read,
    input  wire logic                  last_write_en,
    input  wire ppu_bus_pkg::ppu_byte_t last_write,
    output ppu_bus_pkg::ppu_byte_t     status
);
    import ppu_bus_pkg::*;

    ppu_byte_t status_q;
    logic      clr_d1;
    logic      clr_d2;
    logic      vblank_kill;

    // delayed read clear or external clear, either one flushes the pipe
    assign vblank_kill = vblank_clr | clr_d2;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            status_q <= '0;
            clr_d1   <= 1'b0;
            clr_d2   <= 1'b0;
        end else begin
            // open bus bits
            if (last_write_en) begin
                status_q[4:0] <= last_write[4:0];
            end
            clr_d1 <= status_read;
            clr_d2 <= clr_d1;

            if (sp_over_clr) begin
                status_q[5] <= 1'b0;
            end else if (sp_over_set) begin
                status_q[5] <= 1'b1;
            end

            if (sp_zero_clr) begin
                status_q[6] <= 1'b0;
            end else if (sp_zero_set) begin
                status_q[6] <= 1'b1;
            end

            if (vblank_kill) begin
                status_q[7] <= 1'b0;
                clr_d1      <= 1'b0;
                clr_d2      <= 1'b0;
            end else if (vblank_set) begin
                status_q[7] <= 1'b1;
            end
        end
    end

    assign status = status_q;

endmodule

`default_nettype wire

/* source/ppu_reg_inter.sv */
`default_nettype none

`include "ppu_reg_params.svh"

module ppu_reg_inter (
    input  wire logic                      clk,
    input  wire logic                      rst_n,
    input  wire ppu_bus_pkg::reg_sel_t     reg_sel,
    input  wire logic                      reg_en,
    input  wire logic                      reg_rw,
    input  wire ppu_bus_pkg::ppu_byte_t    reg_data_in,
    output ppu_bus_pkg::ppu_byte_t         reg_data_out,
    input  wire logic                      sp_over_set,
    input  wire logic                      sp_over_clr,
    input  wire logic                      sp_zero_set,
    input  wire logic                      sp_zero_clr,
    input  wire logic                      vblank_set,
    input  wire logic                      vblank_clr,
    input  wire logic                      h_scroll,
    input  wire logic                      v_scroll,
    input  wire logic                      h_update,
    input  wire logic                      v_update,
    input  wire logic                      rendering,
    input  wire ppu_vram_pkg::mirror_t     mirroring,
    output ppu_vram_pkg::vram_addr_t       vram_addr,
    output logic                           vram_we,
    output logic                           vram_re,
    output ppu_bus_pkg::ppu_byte_t         vram_wr_data,
    input  wire ppu_bus_pkg::ppu_byte_t    vram_rd_data,
    output ppu_vram_pkg::pal_addr_t        pal_addr,
    output logic                           pal_we,
    output logic                           pal_re,
    output ppu_bus_pkg::ppu_byte_t         pal_wr_data,
    input  wire ppu_bus_pkg::ppu_byte_t    pal_rd_data,
    output ppu_bus_pkg::ppu_byte_t         ppuctrl,
    output ppu_bus_pkg::ppu_byte_t         ppumask,
    output ppu_vram_pkg::loopy_addr_t      v_addr,
    output ppu_vram_pkg::fine_x_t          fine_x
);
    import ppu_bus_pkg::*;
    import ppu_vram_pkg::*;

    loopy_addr_t t_addr;
    loopy_addr_t v_in;
    loopy_addr_t t_in;
    loopy_addr_t v_step;
    fine_x_t     fine_x_in;
    logic        v_load;
    logic        t_load;
    logic        fine_x_load;
    ppu_byte_t   ppuctrl_next;
    ppu_byte_t   ppumask_next;
    ppu_byte_t   read_buf;
    ppu_byte_t   read_buf_next;
    ppu_byte_t   reg_data_out_next;
    ppu_byte_t   status;
    wr_toggle_t  toggle;
    wr_toggle_t  toggle_next;
    mem_region_t region;
    logic        status_read;
    logic        last_write_en;

    loopy_addr_reg i_loopy (
        .clk, .rst_n,
        .v_load, .t_load, .fine_x_load,
        .v_in, .t_in, .fine_x_in,
        .h_scroll, .v_scroll, .h_update, .v_update, .rendering,
        .v_addr, .t_addr, .fine_x
    );

    ppu_mem_map i_mem_map (
        .v_addr, .mirroring, .region, .vram_addr, .pal_addr
    );

    ppu_status_flags i_status (
        .clk, .rst_n,
        .sp_over_set, .sp_over_clr, .sp_zero_set, .sp_zero_clr,
        .vblank_set, .vblank_clr,
        .status_read, .last_write_en,
        .last_write (reg_data_in),
        .status
    );

    // data port step, across a row or down a column
    assign v_step = v_addr + (ppuctrl[2] ? `PPU_INC_DOWN : `PPU_INC_ACROSS);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ppuctrl      <= '0;
            ppumask      <= '0;
            toggle       <= FIRST_WRITE;
            read_buf     <= '0;
            reg_data_out <= '0;
        end else begin
            ppuctrl      <= ppuctrl_next;
            ppumask      <= ppumask_next;
            toggle       <= toggle_next;
            read_buf     <= read_buf_next;
            reg_data_out <= reg_data_out_next;
        end
    end

    always_comb begin
        ppuctrl_next      = ppuctrl;
        ppumask_next      = ppumask;
        toggle_next       = toggle;
        read_buf_next     = read_buf;
        reg_data_out_next = reg_data_out;
        v_in              = v_addr;
        t_in              = t_addr;
        fine_x_in         = fine_x;
        v_load            = 1'b0;
        t_load            = 1'b0;
        fine_x_load       = 1'b0;
        vram_we           = 1'b0;
        vram_re           = 1'b0;
        vram_wr_data      = '0;
        pal_we            = 1'b0;
        pal_re            = 1'b0;
        pal_wr_data       = '0;
        status_read       = 1'b0;
        last_write_en     = 1'b0;
        if (reg_en) begin
            case (reg_sel)
                PPUCTRL: begin
                    if (reg_rw) begin
                        ppuctrl_next   = reg_data_in;
                        // base nametable select
                        t_in[11:10]    = reg_data_in[1:0];
                        t_load         = 1'b1;
                        last_write_en  = 1'b1;
                    end
                end
                PPUMASK: begin
                    if (reg_rw) begin
                        ppumask_next  = reg_data_in;
                        last_write_en = 1'b1;
                    end
                end
                PPUSTATUS: begin
                    if (!reg_rw) begin
                        reg_data_out_next = status;
                        status_read       = 1'b1;
                        toggle_next       = FIRST_WRITE;
                    end
                end
                PPUSCROLL: begin
                    if (reg_rw) begin
                        t_load        = 1'b1;
                        last_write_en = 1'b1;
                        if (toggle == FIRST_WRITE) begin
                            fine_x_in   = reg_data_in[2:0];
                            fine_x_load = 1'b1;
                            t_in[4:0]   = reg_data_in[7:3];
                            toggle_next = SECOND_WRITE;
                        end else begin
                            t_in[14:12] = reg_data_in[2:0];
                            t_in[9:5]   = reg_data_in[7:3];
                            toggle_next = FIRST_WRITE;
                        end
                    end
                end
                PPUADDR: begin
                    if (reg_rw) begin
                        t_load        = 1'b1;
                        last_write_en = 1'b1;
                        if (toggle == FIRST_WRITE) begin
                            // top bit of the 15-bit address is dropped
                            t_in[14:8]  = {1'b0, reg_data_in[5:0]};
                            toggle_next = SECOND_WRITE;
                        end else begin
                            t_in[7:0]   = reg_data_in;
                            v_in        = {t_addr[14:8], reg_data_in};
                            v_load      = 1'b1;
                            toggle_next = FIRST_WRITE;
                        end
                    end
                end
                PPUDATA: begin
                    v_in   = v_step;
                    v_load = 1'b1;
                    if (reg_rw) begin
                        last_write_en = 1'b1;
                        if (region == REGION_NAMETABLE) begin
                            vram_we      = 1'b1;
                            vram_wr_data = reg_data_in;
                        end else if (region == REGION_PALETTE) begin
                            pal_we      = 1'b1;
                            pal_wr_data = reg_data_in;
                        end
                    end else begin
                        // palette bypasses the buffer, nametable goes through it
                        if (region == REGION_NAMETABLE) begin
                            vram_re           = 1'b1;
                            read_buf_next     = vram_rd_data;
                            reg_data_out_next = read_buf;
                        end else if (region == REGION_PALETTE) begin
                            pal_re            = 1'b1;
                            reg_data_out_next = pal_rd_data;
                        end else begin
                            reg_data_out_next = read_buf;
                        end
                    end
                end
                default: begin
                    // OAM offsets are not decoded
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* testbench/ppu_reg_inter_props.sv */
`default_nettype none

module ppu_reg_inter_props (
    input wire logic                   clk,
    input wire logic                   rst_n,
    input wire ppu_bus_pkg::reg_sel_t  reg_sel,
    input wire logic                   reg_en,
    input wire logic                   reg_rw,
    input wire ppu_bus_pkg::ppu_byte_t reg_data_out,
    input wire logic                   vram_we,
    input wire logic                   vram_re,
    input wire logic                   pal_we,
    input wire logic                   pal_re
);
    import ppu_bus_pkg::*;

    logic        read_strobe;
    int unsigned fail_count;

    initial fail_count = 0;

    // status and data port reads are the only loads of the output byte
    assign read_strobe = reg_en && !reg_rw && (reg_sel == PPUSTATUS || reg_sel == PPUDATA);

    a_single_writer: assert property (@(posedge clk) disable iff (!rst_n)
        !(vram_we && pal_we))
        else begin
            fail_count = fail_count + 1;
            $error("vram_we and pal_we asserted in the same cycle");
        end

    a_strobe_needs_en: assert property (@(posedge clk) disable iff (!rst_n)
        (vram_we || vram_re || pal_we || pal_re) |-> reg_en)
        else begin
            fail_count = fail_count + 1;
            $error("memory strobe asserted without reg_en");
        end

    a_out_holds: assert property (@(posedge clk) disable iff (!rst_n)
        !read_strobe |=> $stable(reg_data_out))
        else begin
            fail_count = fail_count + 1;
            $error("reg_data_out changed although no read took place");
        end

endmodule

bind ppu_reg_inter ppu_reg_inter_props i_props (.*);

`default_nettype wire

/* testbench/ppu_reg_inter_tb.sv */
`default_nettype none

`include "ppu_reg_params.svh"

module ppu_reg_inter_tb;
    import ppu_bus_pkg::*;
    import ppu_vram_pkg::*;

    localparam int CLK_PERIOD      = 20;
    localparam int RESET_CYCLES    = 3;
    localparam int TEST_CYCLES     = 4000;
    localparam int WATCHDOG_MARGIN = 50 * CLK_PERIOD;
    localparam int NT_SIZE         = 1 << `PPU_VRAM_AW;
    localparam int PAL_SIZE        = 1 << `PPU_PAL_AW;

    logic        clk;
    logic        rst_n;
    reg_sel_t    reg_sel;
    logic        reg_en;
    logic        reg_rw;
    ppu_byte_t   reg_data_in;
    ppu_byte_t   reg_data_out;
    logic        sp_over_set;
    logic        sp_over_clr;
    logic        sp_zero_set;
    logic        sp_zero_clr;
    logic        vblank_set;
    logic        vblank_clr;
    logic        h_scroll;
    logic        v_scroll;
    logic        h_update;
    logic        v_update;
    logic        rendering;
    mirror_t     mirroring;
    vram_addr_t  vram_addr;
    logic        vram_we;
    logic        vram_re;
    ppu_byte_t   vram_wr_data;
    ppu_byte_t   vram_rd_data;
    pal_addr_t   pal_addr;
    logic        pal_we;
    logic        pal_re;
    ppu_byte_t   pal_wr_data;
    ppu_byte_t   pal_rd_data;
    ppu_byte_t   ppuctrl;
    ppu_byte_t   ppumask;
    loopy_addr_t v_addr;
    fine_x_t     fine_x;

    integer      seed;

    // reference model state as it stands after the last clock edge
    loopy_addr_t m_v;
    loopy_addr_t m_t;
    fine_x_t     m_fx;
    ppu_byte_t   m_ctrl;
    ppu_byte_t   m_mask;
    ppu_byte_t   m_buf;
    ppu_byte_t   m_out;
    ppu_byte_t   m_status;
    wr_toggle_t  m_tog;
    logic        m_clr1;
    logic        m_clr2;

    ppu_byte_t   nt_mem [0:NT_SIZE-1];
    ppu_byte_t   pal_mem [0:PAL_SIZE-1];

    ppu_reg_inter i_dut (.*);

    // memories with asynchronous read
    assign vram_rd_data = nt_mem[vram_addr];
    assign pal_rd_data  = pal_mem[pal_addr];

    always @(posedge clk) begin
        if (vram_we)
            nt_mem[vram_addr] <= vram_wr_data;
        if (pal_we)
            pal_mem[pal_addr] <= pal_wr_data;
    end

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic abort_run();
        $display("=== FAIL ===");
        $fatal(1, "stopping at first mismatch");
    endtask

    task automatic check_byte(input string name, input ppu_byte_t got, input ppu_byte_t exp);
        if (got !== exp) begin
            $display("FAIL %s: got 0x%h expected 0x%h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_loopy(input string name, input loopy_addr_t got,
                               input loopy_addr_t exp);
        if (got !== exp) begin
            $display("FAIL %s: got 0x%h expected 0x%h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_fine_x(input string name, input fine_x_t got, input fine_x_t exp);
        if (got !== exp) begin
            $display("FAIL %s: got 0x%h expected 0x%h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_vram_addr(input string name, input vram_addr_t got,
                                   input vram_addr_t exp);
        if (got !== exp) begin
            $display("FAIL %s: got 0x%h expected 0x%h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_pal_addr(input string name, input pal_addr_t got,
                                  input pal_addr_t exp);
        if (got !== exp) begin
            $display("FAIL %s: got 0x%h expected 0x%h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("FAIL %s: got 0x%h expected 0x%h", name, got, exp);
            abort_run();
        end
    endtask

    function automatic mem_region_t expect_region(input loopy_addr_t v);
        if (v[13:0] < `PPU_NT_BASE)
            return REGION_PATTERN;
        if (v[13:0] < `PPU_PAL_BASE)
            return REGION_NAMETABLE;
        return REGION_PALETTE;
    endfunction

    // vertical keeps A10 and horizontal takes A11 as the table select
    function automatic vram_addr_t expect_vram_addr(input loopy_addr_t v, input mirror_t mir);
        if (mir == MIRROR_VERTICAL)
            return {v[10], v[9:0]};
        return {v[11], v[9:0]};
    endfunction

    function automatic pal_addr_t expect_pal_addr(input loopy_addr_t v);
        pal_addr_t a;
        a = v[4:0];
        if (a == 5'h10 || a == 5'h14 || a == 5'h18 || a == 5'h1C)
            a = a - 5'h10;
        return a;
    endfunction

    task automatic drive_random(input logic [31:0] cycle);
        logic [31:0] r1;
        logic [31:0] r2;
        r1 = $random(seed);
        r2 = $random(seed);
        reg_en  <= r1[0] | r1[1];
        reg_rw  <= r1[2];
        reg_sel <= reg_sel_t'(r1[5:3]);
        // push half of the high address writes into the palette page
        if (reg_sel_t'(r1[5:3]) == PPUADDR && r1[6])
            reg_data_in <= 8'h3F;
        else
            reg_data_in <= r1[15:8];
        sp_over_set <= (r2[2:0] == 3'd0);
        sp_over_clr <= (r2[5:3] == 3'd0);
        sp_zero_set <= (r2[8:6] == 3'd0);
        sp_zero_clr <= (r2[11:9] == 3'd0);
        vblank_set  <= (r2[14:12] == 3'd0);
        vblank_clr  <= (r2[17:15] == 3'd0);
        h_scroll    <= r2[18];
        v_scroll    <= r2[19] & r2[20];
        h_update    <= r2[21] & r2[22];
        v_update    <= r2[23] & r2[24];
        // rendering only in odd phases while scroll pulses run in both
        rendering   <= cycle[9] & (r2[25] | r2[26]);
        mirroring   <= mirror_t'(cycle[8]);
    endtask

    task automatic check_cycle();
        mem_region_t region;
        logic        data_acc;
        logic        exp_vram_we;
        logic        exp_pal_we;
        region      = expect_region(m_v);
        data_acc    = reg_en && reg_sel == PPUDATA;
        exp_vram_we = data_acc && reg_rw && region == REGION_NAMETABLE;
        exp_pal_we  = data_acc && reg_rw && region == REGION_PALETTE;
        check_byte("ppuctrl", ppuctrl, m_ctrl);
        check_byte("ppumask", ppumask, m_mask);
        check_byte("reg_data_out", reg_data_out, m_out);
        check_loopy("v_addr", v_addr, m_v);
        check_fine_x("fine_x", fine_x, m_fx);
        check_vram_addr("vram_addr", vram_addr, expect_vram_addr(m_v, mirroring));
        check_pal_addr("pal_addr", pal_addr, expect_pal_addr(m_v));
        check_bit("vram_we", vram_we, exp_vram_we);
        check_bit("vram_re", vram_re, data_acc && !reg_rw && region == REGION_NAMETABLE);
        check_bit("pal_we", pal_we, exp_pal_we);
        check_bit("pal_re", pal_re, data_acc && !reg_rw && region == REGION_PALETTE);
        if (exp_vram_we)
            check_byte("vram_wr_data", vram_wr_data, reg_data_in);
        if (exp_pal_we)
            check_byte("pal_wr_data", pal_wr_data, reg_data_in);
    endtask

    task automatic advance_model();
        loopy_addr_t n_v;
        loopy_addr_t n_t;
        mem_region_t region;
        logic        loaded;
        logic        last_wr;
        logic        stat_rd;
        logic [2:0]  fine_y;
        n_v     = m_v;
        n_t     = m_t;
        region  = expect_region(m_v);
        loaded  = 1'b0;
        last_wr = 1'b0;
        stat_rd = 1'b0;
        if (reg_en) begin
            case (reg_sel)
                PPUCTRL: if (reg_rw) begin
                    m_ctrl     = reg_data_in;
                    n_t[11:10] = reg_data_in[1:0];
                    last_wr    = 1'b1;
                end
                PPUMASK: if (reg_rw) begin
                    m_mask  = reg_data_in;
                    last_wr = 1'b1;
                end
                PPUSTATUS: if (!reg_rw) begin
                    m_out   = m_status;
                    stat_rd = 1'b1;
                    m_tog   = FIRST_WRITE;
                end
                PPUSCROLL: if (reg_rw) begin
                    last_wr = 1'b1;
                    if (m_tog == FIRST_WRITE) begin
                        m_fx     = reg_data_in[2:0];
                        n_t[4:0] = reg_data_in[7:3];
                        m_tog    = SECOND_WRITE;
                    end else begin
                        n_t[14:12] = reg_data_in[2:0];
                        n_t[9:5]   = reg_data_in[7:3];
                        m_tog      = FIRST_WRITE;
                    end
                end
                PPUADDR: if (reg_rw) begin
                    last_wr = 1'b1;
                    if (m_tog == FIRST_WRITE) begin
                        n_t[14]   = 1'b0;
                        n_t[13:8] = reg_data_in[5:0];
                        m_tog     = SECOND_WRITE;
                    end else begin
                        n_t[7:0] = reg_data_in;
                        n_v      = n_t;
                        loaded   = 1'b1;
                        m_tog    = FIRST_WRITE;
                    end
                end
                PPUDATA: begin
                    n_v    = m_v + (m_ctrl[2] ? `PPU_INC_DOWN : `PPU_INC_ACROSS);
                    loaded = 1'b1;
                    if (reg_rw) begin
                        last_wr = 1'b1;
                    end else if (region == REGION_NAMETABLE) begin
                        m_out = m_buf;
                        m_buf = nt_mem[expect_vram_addr(m_v, mirroring)];
                    end else if (region == REGION_PALETTE) begin
                        m_out = pal_mem[expect_pal_addr(m_v)];
                    end else begin
                        m_out = m_buf;
                    end
                end
                default: ;
            endcase
        end
        // render-time moves are skipped when the cpu loaded v this cycle
        if (!loaded && rendering) begin
            if (h_scroll) begin
                if (m_v[4:0] == `PPU_COARSE_MAX) begin
                    n_v[4:0] = 5'd0;
                    n_v[10]  = ~m_v[10];
                end else begin
                    n_v[4:0] = m_v[4:0] + 5'd1;
                end
            end else if (v_scroll) begin
                fine_y     = m_v[14:12] + 3'd1;
                n_v[14:12] = fine_y;
                if (fine_y == 3'd0) begin
                    if (m_v[9:5] == `PPU_COARSE_ROWS_END) begin
                        n_v[9:5] = 5'd0;
                        n_v[11]  = ~m_v[11];
                    end else if (m_v[9:5] == `PPU_COARSE_MAX) begin
                        n_v[9:5] = 5'd0;
                    end else begin
                        n_v[9:5] = m_v[9:5] + 5'd1;
                    end
                end
            end else if (h_update) begin
                n_v[10]  = m_t[10];
                n_v[4:0] = m_t[4:0];
            end else if (v_update) begin
                n_v[14:11] = m_t[14:11];
                n_v[9:5]   = m_t[9:5];
            end
        end
        if (last_wr)
            m_status[4:0] = reg_data_in[4:0];
        if (sp_over_clr)
            m_status[5] = 1'b0;
        else if (sp_over_set)
            m_status[5] = 1'b1;
        if (sp_zero_clr)
            m_status[6] = 1'b0;
        else if (sp_zero_set)
            m_status[6] = 1'b1;
        // a clear flushes the delayed read clear too
        if (vblank_clr || m_clr2) begin
            m_status[7] = 1'b0;
            m_clr1      = 1'b0;
            m_clr2      = 1'b0;
        end else begin
            if (vblank_set)
                m_status[7] = 1'b1;
            m_clr2 = m_clr1;
            m_clr1 = stat_rd;
        end
        m_v = n_v;
        m_t = n_t;
    endtask

    initial begin
        seed   = 47;
        for (int i = 0; i < NT_SIZE; i++)
            nt_mem[i] = ppu_byte_t'((i * 29) ^ (i >> 8));
        for (int i = 0; i < PAL_SIZE; i++)
            pal_mem[i] = ppu_byte_t'(8'hA5 ^ (i * 11));
        rst_n       = 1'b0;
        reg_sel     = PPUCTRL;
        reg_en      = 1'b0;
        reg_rw      = 1'b0;
        reg_data_in = '0;
        sp_over_set = 1'b0;
        sp_over_clr = 1'b0;
        sp_zero_set = 1'b0;
        sp_zero_clr = 1'b0;
        vblank_set  = 1'b0;
        vblank_clr  = 1'b0;
        h_scroll    = 1'b0;
        v_scroll    = 1'b0;
        h_update    = 1'b0;
        v_update    = 1'b0;
        rendering   = 1'b0;
        mirroring   = MIRROR_HORIZONTAL;
        m_v      = '0;
        m_t      = '0;
        m_fx     = '0;
        m_ctrl   = '0;
        m_mask   = '0;
        m_buf    = '0;
        m_out    = '0;
        m_status = '0;
        m_tog    = FIRST_WRITE;
        m_clr1   = 1'b0;
        m_clr2   = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        for (int cyc = 0; cyc < TEST_CYCLES; cyc++) begin
            @(posedge clk);
            drive_random(cyc);
            // inputs and outputs are settled mid cycle
            @(negedge clk);
            check_cycle();
            advance_model();
        end
        $display("=== PASS ===");
        $finish;
    end

    // a failing bound assertion ends the run as well
    initial begin
        wait (i_dut.i_props.fail_count != 0);
        $display("a bound assertion on the DUT failed");
        $display("=== FAIL ===");
        $fatal(1, "assertion failure");
    end

    initial begin
        #((RESET_CYCLES + TEST_CYCLES) * CLK_PERIOD + WATCHDOG_MARGIN);
        $display("watchdog expired before the random sequence completed");
        $display("=== FAIL ===");
        $fatal(1, "timeout");
    end

endmodule

`default_nettype wire

/* ppu_reg_inter.f */
+incdir+common
common/ppu_bus_pkg.sv
common/ppu_vram_pkg.sv
scroll/loopy_addr_reg.sv
source/ppu_mem_map.sv
source/ppu_status_flags.sv
source/ppu_reg_inter.sv
testbench/ppu_reg_inter_props.sv
testbench/ppu_reg_inter_tb.sv
